//--- hw/rv_ex_pkg.sv
package rv_ex_pkg;

	localparam int xlen = 32;

	// rv32 major opcodes
	typedef enum logic [6:0] {
		op_rtype  = 7'b0110011,
		op_itype  = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111
	} opcode_e;

	// {funct7[5], funct3}, lui borrows an unused sub code
	typedef enum logic [3:0] {
		alu_add  = 4'b0000,
		alu_sll  = 4'b0001,
		alu_slt  = 4'b0010,
		alu_sltu = 4'b0011,
		alu_xor  = 4'b0100,
		alu_srl  = 4'b0101,
		alu_or   = 4'b0110,
		alu_and  = 4'b0111,
		alu_sub  = 4'b1000,
		alu_lui  = 4'b1001,
		alu_sra  = 4'b1101
	} alu_op_e;

	typedef enum logic [1:0] {mul_lo, mul_hh, mul_hsu, mul_hu} mul_op_e;

	typedef enum logic [1:0] {res_alu, res_mul, res_link} res_sel_e;

	typedef enum logic [1:0] {fwd_reg, fwd_ex, fwd_mem, fwd_wb} fwd_sel_e;

	typedef enum logic [1:0] {pc_next, pc_redirect, pc_hold} pc_sel_e;

	typedef enum logic [1:0] {ins_normal, ins_hold, ins_flush} instr_sel_e;

	typedef enum logic [2:0] {ld_none, ld_b, ld_h, ld_w, ld_hu, ld_bu} load_kind_e;

	typedef enum logic [1:0] {st_none, st_w, st_h, st_b} store_kind_e;

	// low two bits pick the compare, top bit inverts it
	typedef enum logic [2:0] {
		br_none = 3'b000,
		br_eq   = 3'b001,
		br_lt   = 3'b010,
		br_ltu  = 3'b011,
		br_ne   = 3'b101,
		br_ge   = 3'b110,
		br_geu  = 3'b111
	} branch_kind_e;

endpackage

//--- hw/ex_control.sv
`timescale 1ns/1ps

module ex_control (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [31:0]             instr,
	input  logic                    taken,
	input  logic [4:0]              rd_addr_mem,
	input  logic                    wb_en_mem,
	input  logic [4:0]              rd_addr_wb,
	input  logic                    wb_en_wb,
	output rv_ex_pkg::alu_op_e      alu_op,
	output rv_ex_pkg::mul_op_e      mul_op,
	output rv_ex_pkg::res_sel_e     res_sel,
	output rv_ex_pkg::fwd_sel_e     fwd1_sel,
	output rv_ex_pkg::fwd_sel_e     fwd2_sel,
	output logic                    op1_pc,
	output logic                    op2_imm,
	output logic                    dm_web,
	output rv_ex_pkg::load_kind_e   load_kind,
	output rv_ex_pkg::store_kind_e  store_kind,
	output rv_ex_pkg::branch_kind_e branch_kind,
	output logic                    wb_en,
	output logic [4:0]              rd_addr_ex,
	output logic                    load_use_bubble,
	output rv_ex_pkg::pc_sel_e      pc_sel,
	output rv_ex_pkg::instr_sel_e   instr_sel
);

	rv_ex_pkg::opcode_e        opcode;
	logic [2:0]                funct3;
	logic [4:0]                rs1_addr;
	logic [4:0]                rs2_addr;
	logic                      uses_rs1;
	logic                      uses_rs2;
	logic                      is_mul;
	logic                      is_jump;
	logic                      writes_rd;
	logic                      redirect;
	logic                      kill;       // slot entering execute is squashed
	logic                      ex_jump;    // jal/jalr now in execute
	logic                      hold_q;     // load-use seen last cycle
	rv_ex_pkg::alu_op_e        alu_op_d;
	rv_ex_pkg::load_kind_e     ld_kind_d;
	rv_ex_pkg::store_kind_e    st_kind_d;
	rv_ex_pkg::branch_kind_e   br_kind_d;

	assign opcode   = rv_ex_pkg::opcode_e'(instr[6:0]);
	assign funct3   = instr[14:12];
	assign rs1_addr = instr[19:15];
	assign rs2_addr = instr[24:20];
	assign is_mul   = (opcode == rv_ex_pkg::op_rtype) && instr[25];
	assign is_jump  = (opcode == rv_ex_pkg::op_jal) || (opcode == rv_ex_pkg::op_jalr);

	assign uses_rs1 = !(opcode == rv_ex_pkg::op_lui || opcode == rv_ex_pkg::op_auipc ||
		opcode == rv_ex_pkg::op_jal);
	assign uses_rs2 = (opcode == rv_ex_pkg::op_rtype) || (opcode == rv_ex_pkg::op_store) ||
		(opcode == rv_ex_pkg::op_branch);

	// youngest producer wins, x0 is never forwarded
	function automatic rv_ex_pkg::fwd_sel_e fwd_pick(
		input logic [4:0] rs,
		input logic [4:0] rd_ex,
		input logic       en_ex,
		input logic [4:0] rd_mem,
		input logic       en_mem,
		input logic [4:0] rd_wb,
		input logic       en_wb
	);
		if (rs == 5'd0)
			return rv_ex_pkg::fwd_reg;
		else if (en_ex && rs == rd_ex)
			return rv_ex_pkg::fwd_ex;
		else if (en_mem && rs == rd_mem)
			return rv_ex_pkg::fwd_mem;
		else if (en_wb && rs == rd_wb)
			return rv_ex_pkg::fwd_wb;
		else
			return rv_ex_pkg::fwd_reg;
	endfunction

	always_comb begin
		alu_op_d  = rv_ex_pkg::alu_add;
		ld_kind_d = rv_ex_pkg::ld_none;
		st_kind_d = rv_ex_pkg::st_none;
		br_kind_d = rv_ex_pkg::br_none;
		writes_rd = 1'b1;
		case (opcode)
			rv_ex_pkg::op_rtype: begin
				if (!instr[25])
					alu_op_d = rv_ex_pkg::alu_op_e'({instr[30], funct3});
			end
			rv_ex_pkg::op_itype: begin
				if (funct3 == 3'b001 || funct3 == 3'b101)
					alu_op_d = rv_ex_pkg::alu_op_e'({instr[30], funct3}); // srai keeps bit 30
				else
					alu_op_d = rv_ex_pkg::alu_op_e'({1'b0, funct3});
			end
			rv_ex_pkg::op_lui: alu_op_d = rv_ex_pkg::alu_lui;
			rv_ex_pkg::op_auipc, rv_ex_pkg::op_jal, rv_ex_pkg::op_jalr: alu_op_d = rv_ex_pkg::alu_add;
			rv_ex_pkg::op_load: begin
				case (funct3)
					3'b000:  ld_kind_d = rv_ex_pkg::ld_b;
					3'b001:  ld_kind_d = rv_ex_pkg::ld_h;
					3'b010:  ld_kind_d = rv_ex_pkg::ld_w;
					3'b100:  ld_kind_d = rv_ex_pkg::ld_bu;
					3'b101:  ld_kind_d = rv_ex_pkg::ld_hu;
					default: writes_rd = 1'b0; // bad width, treat as nop
				endcase
			end
			rv_ex_pkg::op_store: begin
				writes_rd = 1'b0;
				case (funct3)
					3'b000:  st_kind_d = rv_ex_pkg::st_b;
					3'b001:  st_kind_d = rv_ex_pkg::st_h;
					3'b010:  st_kind_d = rv_ex_pkg::st_w;
					default: st_kind_d = rv_ex_pkg::st_none;
				endcase
			end
			rv_ex_pkg::op_branch: begin
				writes_rd = 1'b0;
				case (funct3)
					3'b000:  br_kind_d = rv_ex_pkg::br_eq;
					3'b001:  br_kind_d = rv_ex_pkg::br_ne;
					3'b100:  br_kind_d = rv_ex_pkg::br_lt;
					3'b101:  br_kind_d = rv_ex_pkg::br_ge;
					3'b110:  br_kind_d = rv_ex_pkg::br_ltu;
					3'b111:  br_kind_d = rv_ex_pkg::br_geu;
					default: br_kind_d = rv_ex_pkg::br_none;
				endcase
			end
			default: writes_rd = 1'b0;
		endcase
	end

	assign kill = load_use_bubble || redirect;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			alu_op      <= rv_ex_pkg::alu_add;
			mul_op      <= rv_ex_pkg::mul_lo;
			res_sel     <= rv_ex_pkg::res_alu;
			fwd1_sel    <= rv_ex_pkg::fwd_reg;
			fwd2_sel    <= rv_ex_pkg::fwd_reg;
			op1_pc      <= 1'b0;
			op2_imm     <= 1'b0;
			dm_web      <= 1'b1; // read
			load_kind   <= rv_ex_pkg::ld_none;
			store_kind  <= rv_ex_pkg::st_none;
			branch_kind <= rv_ex_pkg::br_none;
			wb_en       <= 1'b0;
			rd_addr_ex  <= 5'd0;
			ex_jump     <= 1'b0;
			hold_q      <= 1'b0;
		end else begin
			alu_op   <= alu_op_d;
			mul_op   <= rv_ex_pkg::mul_op_e'(funct3[1:0]);
			res_sel  <= is_mul ? rv_ex_pkg::res_mul :
				is_jump ? rv_ex_pkg::res_link : rv_ex_pkg::res_alu;
			fwd1_sel <= fwd_pick(rs1_addr, rd_addr_ex, wb_en, rd_addr_mem, wb_en_mem,
				rd_addr_wb, wb_en_wb);
			fwd2_sel <= fwd_pick(rs2_addr, rd_addr_ex, wb_en, rd_addr_mem, wb_en_mem,
				rd_addr_wb, wb_en_wb);
			op1_pc   <= (opcode == rv_ex_pkg::op_branch) || (opcode == rv_ex_pkg::op_auipc) ||
				(opcode == rv_ex_pkg::op_jal);
			op2_imm  <= (opcode != rv_ex_pkg::op_rtype);
			rd_addr_ex <= instr[11:7];
			hold_q     <= load_use_bubble;
			// a squashed slot writes nothing and never branches
			wb_en       <= writes_rd && !kill;
			dm_web      <= kill || (st_kind_d == rv_ex_pkg::st_none);
			load_kind   <= kill ? rv_ex_pkg::ld_none : ld_kind_d;
			store_kind  <= kill ? rv_ex_pkg::st_none : st_kind_d;
			branch_kind <= kill ? rv_ex_pkg::br_none : br_kind_d;
			ex_jump     <= is_jump && !kill;
		end
	end

	// load in execute feeding the instruction in decode
	assign load_use_bubble = (load_kind != rv_ex_pkg::ld_none) && (rd_addr_ex != 5'd0) &&
		((uses_rs1 && rs1_addr == rd_addr_ex) || (uses_rs2 && rs2_addr == rd_addr_ex));

	assign redirect = ex_jump || taken; // taken stays low unless a branch sits in execute

	always_comb begin
		if (redirect)
			pc_sel = rv_ex_pkg::pc_redirect;
		else if (load_use_bubble)
			pc_sel = rv_ex_pkg::pc_hold;
		else
			pc_sel = rv_ex_pkg::pc_next;
	end

	always_comb begin
		if (redirect)
			instr_sel = rv_ex_pkg::ins_flush;
		else if (hold_q)
			instr_sel = rv_ex_pkg::ins_hold; // fetch re-presents the stalled word
		else
			instr_sel = rv_ex_pkg::ins_normal;
	end

endmodule

//--- hw/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
	input  logic [31:0] instr,
	output logic [31:0] imm
);

	rv_ex_pkg::opcode_e opcode;
	logic               sign;

	assign opcode = rv_ex_pkg::opcode_e'(instr[6:0]);
	assign sign   = instr[31];

	always_comb begin
		case (opcode)
			rv_ex_pkg::op_itype, rv_ex_pkg::op_load, rv_ex_pkg::op_jalr:
				imm = {{20{sign}}, instr[31:20]};
			rv_ex_pkg::op_store:
				imm = {{20{sign}}, instr[31:25], instr[11:7]};
			// b format, bit 0 always zero
			rv_ex_pkg::op_branch:
				imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
			rv_ex_pkg::op_lui, rv_ex_pkg::op_auipc:
				imm = {instr[31:12], 12'd0}; // upper 20 bits
			rv_ex_pkg::op_jal:
				imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
			default:
				imm = 32'd0;
		endcase
	end

endmodule

//--- hw/ex_datapath.sv
`timescale 1ns/1ps

module ex_datapath (
	input  logic                clk,
	input  logic                rst,
	input  logic                load_use_bubble,
	input  logic [31:0]         pc_id,
	input  logic [31:0]         imm,
	input  logic [31:0]         rs1_data,
	input  logic [31:0]         rs2_data,
	input  rv_ex_pkg::fwd_sel_e fwd1_sel,
	input  rv_ex_pkg::fwd_sel_e fwd2_sel,
	input  logic                op1_pc,
	input  logic                op2_imm,
	input  rv_ex_pkg::res_sel_e res_sel,
	input  logic [31:0]         mem_fwd_data,
	input  logic [31:0]         wb_data,
	input  logic [31:0]         alu_out,
	input  logic [31:0]         mul_out,
	output logic [31:0]         opa,
	output logic [31:0]         opb,
	output logic [31:0]         fwd_rs1,
	output logic [31:0]         fwd_rs2,
	output logic [31:0]         ex_result,
	output logic [31:0]         redirect_pc
);

	logic [rv_ex_pkg::xlen-1:0] pc_q;
	logic [rv_ex_pkg::xlen-1:0] imm_q;
	logic [rv_ex_pkg::xlen-1:0] rs1_q;
	logic [rv_ex_pkg::xlen-1:0] rs2_q;
	logic [rv_ex_pkg::xlen-1:0] exmem_q; // result of the previous instruction

	// id/ex payload, a load-use bubble enters as zeros
	always_ff @(posedge clk) begin
		if (load_use_bubble) begin
			pc_q  <= '0;
			imm_q <= '0;
			rs1_q <= '0;
			rs2_q <= '0;
		end else begin
			pc_q  <= pc_id;
			imm_q <= imm;
			rs1_q <= rs1_data;
			rs2_q <= rs2_data;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			exmem_q <= '0;
		else
			exmem_q <= ex_result;
	end

	function automatic logic [31:0] fwd_mux(
		input rv_ex_pkg::fwd_sel_e sel,
		input logic [31:0]         reg_val,
		input logic [31:0]         ex_val,
		input logic [31:0]         mem_val,
		input logic [31:0]         wb_val
	);
		case (sel)
			rv_ex_pkg::fwd_ex:  return ex_val;
			rv_ex_pkg::fwd_mem: return mem_val;
			rv_ex_pkg::fwd_wb:  return wb_val;
			default:            return reg_val;
		endcase
	endfunction

	assign fwd_rs1 = fwd_mux(fwd1_sel, rs1_q, exmem_q, mem_fwd_data, wb_data);
	assign fwd_rs2 = fwd_mux(fwd2_sel, rs2_q, exmem_q, mem_fwd_data, wb_data);

	assign opa = op1_pc ? pc_q : fwd_rs1;   // pc-relative forms
	assign opb = op2_imm ? imm_q : fwd_rs2;

	always_comb begin
		case (res_sel)
			rv_ex_pkg::res_mul:  ex_result = mul_out;
			rv_ex_pkg::res_link: ex_result = pc_q + 32'd4;
			default:             ex_result = alu_out;
		endcase
	end

	assign redirect_pc = alu_out; // pc+imm or rs1+imm

endmodule

//--- hw/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
	input  logic [31:0]        opa,
	input  logic [31:0]        opb,
	input  rv_ex_pkg::alu_op_e alu_op,
	output logic [31:0]        alu_out
);

	logic [4:0] shamt;

	assign shamt = opb[4:0];

	always_comb begin
		case (alu_op)
			rv_ex_pkg::alu_add:  alu_out = opa + opb;
			rv_ex_pkg::alu_sub:  alu_out = opa - opb;
			rv_ex_pkg::alu_sll:  alu_out = opa << shamt;
			rv_ex_pkg::alu_slt:  alu_out = {31'd0, $signed(opa) < $signed(opb)};
			rv_ex_pkg::alu_sltu: alu_out = {31'd0, opa < opb};
			rv_ex_pkg::alu_xor:  alu_out = opa ^ opb;
			rv_ex_pkg::alu_srl:  alu_out = opa >> shamt;
			rv_ex_pkg::alu_sra:  alu_out = $unsigned($signed(opa) >>> shamt);
			rv_ex_pkg::alu_or:   alu_out = opa | opb;
			rv_ex_pkg::alu_and:  alu_out = opa & opb;
			rv_ex_pkg::alu_lui:  alu_out = opb; // immediate already shifted up
			default:             alu_out = opa + opb;
		endcase
	end

endmodule

//--- hw/ex_mul.sv
`timescale 1ns/1ps

module ex_mul (
	input  logic [31:0]        fwd_rs1,
	input  logic [31:0]        fwd_rs2,
	input  rv_ex_pkg::mul_op_e mul_op,
	output logic [31:0]        mul_out
);

	logic               a_signed;
	logic               b_signed;
	logic signed [32:0] a_ext;
	logic signed [32:0] b_ext;
	logic signed [65:0] prod;

	// one signed multiplier, operands extended per op
	assign a_signed = (mul_op != rv_ex_pkg::mul_hu);
	assign b_signed = (mul_op == rv_ex_pkg::mul_lo) || (mul_op == rv_ex_pkg::mul_hh);
	assign a_ext    = {a_signed & fwd_rs1[31], fwd_rs1};
	assign b_ext    = {b_signed & fwd_rs2[31], fwd_rs2};
	assign prod     = a_ext * b_ext;

	assign mul_out = (mul_op == rv_ex_pkg::mul_lo) ? prod[31:0] : prod[63:32];

endmodule

//--- hw/branch_cmp.sv
`timescale 1ns/1ps

module branch_cmp (
	input  logic [31:0]             fwd_rs1,
	input  logic [31:0]             fwd_rs2,
	input  rv_ex_pkg::branch_kind_e branch_kind,
	output logic                    taken
);

	logic [1:0] cls;
	logic       inv;
	logic       hit;

	assign cls = branch_kind[1:0];
	assign inv = branch_kind[2];   // bne, bge, bgeu

	always_comb begin
		case (cls)
			2'b01:   hit = (fwd_rs1 == fwd_rs2);
			2'b10:   hit = ($signed(fwd_rs1) < $signed(fwd_rs2));
			2'b11:   hit = (fwd_rs1 < fwd_rs2);
			default: hit = 1'b0;
		endcase
	end

	assign taken = (cls != 2'b00) && (hit ^ inv);

endmodule

//--- hw/ex_stage_top.sv
`timescale 1ns/1ps

module ex_stage_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [31:0]             instr,
	input  logic [31:0]             pc_id,
	input  logic [31:0]             rs1_data,
	input  logic [31:0]             rs2_data,
	input  logic [4:0]              rd_addr_mem,
	input  logic                    wb_en_mem,
	input  logic [31:0]             mem_fwd_data,
	input  logic [4:0]              rd_addr_wb,
	input  logic                    wb_en_wb,
	input  logic [31:0]             wb_data,
	output logic [31:0]             ex_result,
	output logic [31:0]             redirect_pc,
	output rv_ex_pkg::pc_sel_e      pc_sel,
	output rv_ex_pkg::instr_sel_e   instr_sel,
	output logic                    dm_web,
	output rv_ex_pkg::load_kind_e   load_kind,
	output rv_ex_pkg::store_kind_e  store_kind,
	output rv_ex_pkg::branch_kind_e branch_kind,
	output logic                    wb_en
);

	rv_ex_pkg::alu_op_e  alu_op;
	rv_ex_pkg::mul_op_e  mul_op;
	rv_ex_pkg::res_sel_e res_sel;
	rv_ex_pkg::fwd_sel_e fwd1_sel;
	rv_ex_pkg::fwd_sel_e fwd2_sel;
	logic                op1_pc;
	logic                op2_imm;
	logic                load_use_bubble;
	logic                taken;
	logic [31:0]         imm;
	logic [31:0]         opa;
	logic [31:0]         opb;
	logic [31:0]         fwd_rs1;
	logic [31:0]         fwd_rs2;
	logic [31:0]         alu_out;
	logic [31:0]         mul_out;

	ex_control u_ctrl (
		.clk(clk), .rst(rst), .instr(instr), .taken(taken),
		.rd_addr_mem(rd_addr_mem), .wb_en_mem(wb_en_mem),
		.rd_addr_wb(rd_addr_wb), .wb_en_wb(wb_en_wb),
		.alu_op(alu_op), .mul_op(mul_op), .res_sel(res_sel),
		.fwd1_sel(fwd1_sel), .fwd2_sel(fwd2_sel), .op1_pc(op1_pc), .op2_imm(op2_imm),
		.dm_web(dm_web), .load_kind(load_kind), .store_kind(store_kind),
		.branch_kind(branch_kind), .wb_en(wb_en), .rd_addr_ex(),
		.load_use_bubble(load_use_bubble), .pc_sel(pc_sel), .instr_sel(instr_sel)
	);

	imm_gen u_imm (.instr(instr), .imm(imm));

	ex_datapath u_dp (
		.clk(clk), .rst(rst), .load_use_bubble(load_use_bubble), .pc_id(pc_id), .imm(imm),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .fwd1_sel(fwd1_sel), .fwd2_sel(fwd2_sel),
		.op1_pc(op1_pc), .op2_imm(op2_imm), .res_sel(res_sel),
		.mem_fwd_data(mem_fwd_data), .wb_data(wb_data), .alu_out(alu_out), .mul_out(mul_out),
		.opa(opa), .opb(opb), .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2),
		.ex_result(ex_result), .redirect_pc(redirect_pc)
	);

	ex_alu u_alu (.opa(opa), .opb(opb), .alu_op(alu_op), .alu_out(alu_out));

	ex_mul u_mul (.fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2), .mul_op(mul_op), .mul_out(mul_out));

	branch_cmp u_br (
		.fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2), .branch_kind(branch_kind), .taken(taken)
	);

endmodule

//--- sim/ex_stage_properties.sv
`timescale 1ns/1ps

module ex_stage_properties (
	input logic                   clk,
	input logic                   rst,
	input rv_ex_pkg::pc_sel_e     pc_sel,
	input rv_ex_pkg::instr_sel_e  instr_sel,
	input logic                   wb_en,
	input logic                   dm_web,
	input rv_ex_pkg::store_kind_e store_kind
);

	// slot behind a redirect is squashed
	assert property (@(posedge clk) disable iff (rst)
		pc_sel == rv_ex_pkg::pc_redirect |=> !wb_en)
		else $error("wb_en high after a redirect");

	assert property (@(posedge clk) disable iff (rst)
		store_kind == rv_ex_pkg::st_none |-> dm_web)
		else $error("dm_web low without a store");

	assert property (@(posedge clk) disable iff (rst)
		pc_sel == rv_ex_pkg::pc_hold |=> instr_sel == rv_ex_pkg::ins_hold)
		else $error("pc_hold not followed by ins_hold");

endmodule

bind ex_control ex_stage_properties u_props (
	.clk(clk), .rst(rst), .pc_sel(pc_sel), .instr_sel(instr_sel),
	.wb_en(wb_en), .dm_web(dm_web), .store_kind(store_kind)
);

//--- sim/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;

	typedef struct packed {
		logic [31:0] result;
		logic [31:0] target;
		logic [2:0]  ld;
		logic [1:0]  st;
		logic [2:0]  br;
		logic        wb;
		logic        web;
		logic        redir;
		logic        hold;
		logic        chk_res;
		logic        chk_tgt;
		logic        chk_pc;
	} pred_t;

	logic        clk;
	logic        rst;
	logic [31:0] instr;
	logic [31:0] pc_id;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic [4:0]  rd_addr_mem;
	logic        wb_en_mem;
	logic [31:0] mem_fwd_data;
	logic [4:0]  rd_addr_wb;
	logic        wb_en_wb;
	logic [31:0] wb_data;
	logic [31:0] ex_result;
	logic [31:0] redirect_pc;
	logic        dm_web;
	logic        wb_en;
	rv_ex_pkg::pc_sel_e      pc_sel;
	rv_ex_pkg::instr_sel_e   instr_sel;
	rv_ex_pkg::load_kind_e   load_kind;
	rv_ex_pkg::store_kind_e  store_kind;
	rv_ex_pkg::branch_kind_e branch_kind;

	pred_t       exp_q[$];
	integer      seed = 32'h2295_07fc;
	integer      checks = 0;
	integer      errors = 0;
	integer      test_err0 = 0;
	logic [31:0] pc = 32'h0000_1000;
	// shadow of the slot now in execute
	logic [4:0]  last_rd = 5'd0;
	logic        last_wb = 1'b0;
	logic        last_ld = 1'b0;
	logic [31:0] last_res = 32'd0;
	logic        kill_next = 1'b0;
	// mem/wb stage inputs applied with the next instruction
	logic [4:0]  n_mem_rd = 5'd0;
	logic        n_mem_en = 1'b0;
	logic [31:0] n_mem_d = 32'd0;
	logic [4:0]  n_wb_rd = 5'd0;
	logic        n_wb_en = 1'b0;
	logic [31:0] n_wb_d = 32'd0;

	localparam logic [31:0] nop = 32'h0000_0013;

	ex_stage_top uut (
		.clk(clk), .rst(rst), .instr(instr), .pc_id(pc_id),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.rd_addr_mem(rd_addr_mem), .wb_en_mem(wb_en_mem), .mem_fwd_data(mem_fwd_data),
		.rd_addr_wb(rd_addr_wb), .wb_en_wb(wb_en_wb), .wb_data(wb_data),
		.ex_result(ex_result), .redirect_pc(redirect_pc), .pc_sel(pc_sel),
		.instr_sel(instr_sel), .dm_web(dm_web), .load_kind(load_kind),
		.store_kind(store_kind), .branch_kind(branch_kind), .wb_en(wb_en)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] imm_of(input logic [31:0] ins);
		case (ins[6:0])
			7'b0100011: return {{20{ins[31]}}, ins[31:25], ins[11:7]};
			7'b1100011: return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			7'b0110111, 7'b0010111: return {ins[31:12], 12'd0};
			7'b1101111: return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			default: return {{20{ins[31]}}, ins[31:20]};
		endcase
	endfunction

	function automatic logic [31:0] alu_rule(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// expected execute outputs from the isa rules
	function automatic pred_t predict_result(input logic [31:0] ins, input logic [31:0] pcv,
		input logic [31:0] a, input logic [31:0] b);
		pred_t       p;
		logic [31:0] imm;
		logic [2:0]  f3;
		logic [63:0] prod;
		logic        t;
		p = '0;
		p.web = 1'b1;
		p.chk_pc = 1'b1;
		imm = imm_of(ins);
		f3 = ins[14:12];
		case (ins[6:0])
			7'b0110011: begin
				p.wb = 1'b1;
				p.chk_res = 1'b1;
				if (ins[25]) begin
					case (f3[1:0])
						2'd1: prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
						2'd2: prod = {{32{a[31]}}, a} * {32'd0, b};
						default: prod = {32'd0, a} * {32'd0, b};
					endcase
					p.result = (f3[1:0] == 2'd0) ? prod[31:0] : prod[63:32];
				end else
					p.result = alu_rule(f3, ins[30], a, b);
			end
			7'b0010011: begin
				p.wb = 1'b1;
				p.chk_res = 1'b1;
				p.result = alu_rule(f3, (f3 == 3'd5) && ins[30], a, imm);
			end
			7'b0110111: {p.wb, p.chk_res, p.result} = {2'b11, imm};
			7'b0010111: {p.wb, p.chk_res, p.result} = {2'b11, pcv + imm};
			7'b1101111, 7'b1100111: begin
				{p.wb, p.chk_res, p.chk_tgt, p.redir} = 4'b1111;
				p.result = pcv + 32'd4; // link
				p.target = (ins[6:0] == 7'b1101111) ? pcv + imm : a + imm;
			end
			7'b1100011: begin
				case (f3[2:1])
					2'b00: t = (a == b);
					2'b10: t = $signed(a) < $signed(b);
					default: t = a < b;
				endcase
				p.redir = t ^ f3[0];
				p.chk_tgt = 1'b1;
				p.target = pcv + imm;
				p.br = {f3[0], (f3[2:1] == 2'b00) ? 2'b01 : {1'b1, f3[1]}};
			end
			7'b0000011: begin
				{p.wb, p.chk_res, p.chk_pc} = 3'b110; // hold depends on the next word
				p.result = a + imm;
				case (f3)
					3'd0: p.ld = rv_ex_pkg::ld_b;
					3'd1: p.ld = rv_ex_pkg::ld_h;
					3'd2: p.ld = rv_ex_pkg::ld_w;
					3'd4: p.ld = rv_ex_pkg::ld_bu;
					default: p.ld = rv_ex_pkg::ld_hu;
				endcase
			end
			7'b0100011: begin
				{p.web, p.chk_res} = 2'b01;
				p.result = a + imm;
				p.st = (f3 == 3'd0) ? rv_ex_pkg::st_b :
					(f3 == 3'd1) ? rv_ex_pkg::st_h : rv_ex_pkg::st_w;
			end
			default: ;
		endcase
		return p;
	endfunction

	// operand value the execute stage should see
	function automatic logic [31:0] fwd_value(input logic [4:0] rs, input logic [31:0] rf);
		if (rs == 5'd0)
			return rf;
		else if (last_wb && rs == last_rd)
			return last_res;
		else if (n_mem_en && rs == n_mem_rd)
			return n_mem_d;
		else if (n_wb_en && rs == n_wb_rd)
			return n_wb_d;
		return rf;
	endfunction

	function automatic logic reads_rs2(input logic [31:0] ins);
		return ins[6:0] == 7'b0110011 || ins[6:0] == 7'b0100011 || ins[6:0] == 7'b1100011;
	endfunction

	function automatic logic reads_rs1(input logic [31:0] ins);
		return !(ins[6:0] == 7'b0110111 || ins[6:0] == 7'b0010111 || ins[6:0] == 7'b1101111);
	endfunction

	task automatic report(input string sig, input logic [31:0] got, input logic [31:0] exp);
		errors++;
		$display("CHECK FAILED t=%0t %s got %h exp %h", $time, sig, got, exp);
	endtask

	task automatic issue(input logic [31:0] ins, input logic [31:0] r1, input logic [31:0] r2);
		pred_t p;
		logic  hazard;
		@(negedge clk);
		instr = ins;
		pc_id = pc;
		rs1_data = r1;
		rs2_data = r2;
		{rd_addr_mem, wb_en_mem, mem_fwd_data} = {n_mem_rd, n_mem_en, n_mem_d};
		{rd_addr_wb, wb_en_wb, wb_data} = {n_wb_rd, n_wb_en, n_wb_d};
		hazard = last_ld && last_rd != 5'd0 && ((reads_rs1(ins) && ins[19:15] == last_rd) ||
			(reads_rs2(ins) && ins[24:20] == last_rd));
		p = predict_result(ins, pc, fwd_value(ins[19:15], r1), fwd_value(ins[24:20], r2));
		if (hazard || kill_next) begin
			{p.wb, p.web, p.ld, p.st, p.br, p.redir} = {2'b01, 9'd0};
			{p.chk_res, p.chk_tgt} = 2'b00;
		end
		p.hold = hazard; // bubble slot sees fetch told to hold
		exp_q.push_back(p);
		kill_next = p.redir;
		last_rd = ins[11:7];
		last_wb = p.wb;
		last_ld = (p.ld != 3'd0);
		last_res = p.result;
		pc = pc + 32'd4;
	endtask

	task automatic set_stages(input logic [4:0] mrd, input logic men, input logic [31:0] md,
		input logic [4:0] wrd, input logic wen, input logic [31:0] wd);
		{n_mem_rd, n_mem_en, n_mem_d} = {mrd, men, md};
		{n_wb_rd, n_wb_en, n_wb_d} = {wrd, wen, wd};
	endtask

	task automatic end_test(input string name);
		integer n;
		set_stages(0, 0, 0, 0, 0, 0);
		issue(nop, 0, 0);
		issue(nop, 0, 0);
		n = 0;
		while (exp_q.size() != 0 && n < 20) begin
			@(posedge clk);
			#20;
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: predictions for %s never drained", name);
			$display("TESTS FAILED");
			$finish;
		end else begin
			$display("%s: %0d errors", name, errors - test_err0);
			test_err0 = errors;
		end
	endtask

	// comparing process, outputs settle well before the falling edge
	initial begin
		pred_t                 p;
		rv_ex_pkg::pc_sel_e    exp_pc;
		rv_ex_pkg::instr_sel_e exp_ins;
		forever begin
			@(posedge clk);
			#10;
			if (!rst && exp_q.size() != 0) begin
				p = exp_q.pop_front();
				checks++;
				exp_pc = p.redir ? rv_ex_pkg::pc_redirect : rv_ex_pkg::pc_next;
				if (p.redir)
					exp_ins = rv_ex_pkg::ins_flush;
				else if (p.hold)
					exp_ins = rv_ex_pkg::ins_hold;
				else
					exp_ins = rv_ex_pkg::ins_normal;
				if (wb_en !== p.wb) report("wb_en", wb_en, p.wb);
				if (dm_web !== p.web) report("dm_web", dm_web, p.web);
				if (load_kind !== p.ld) report("load_kind", load_kind, p.ld);
				if (store_kind !== p.st) report("store_kind", store_kind, p.st);
				if (branch_kind !== p.br) report("branch_kind", branch_kind, p.br);
				if (p.chk_res && ex_result !== p.result) report("ex_result", ex_result, p.result);
				if (p.chk_tgt && redirect_pc !== p.target)
					report("redirect_pc", redirect_pc, p.target);
				if (p.chk_pc && pc_sel !== exp_pc)
					report("pc_sel", pc_sel, exp_pc);
				if (instr_sel !== exp_ins)
					report("instr_sel", instr_sel, exp_ins);
			end
		end
	end

	initial begin
		#5_000_000;
		$display("timeout: simulation limit reached");
		$display("TESTS FAILED");
		$finish;
	end

	task automatic random_alu(output logic [31:0] ins);
		logic [31:0] r;
		logic [2:0]  f3;
		r = $random(seed);
		f3 = r[14:12];
		ins = r;
		ins[11:7] = (r[11:7] == 5'd0) ? 5'd1 : r[11:7];
		case (r[1:0])
			2'd0: ins[6:0] = 7'b0110111;
			2'd1: ins[6:0] = 7'b0010111;
			2'd2: begin
				ins[6:0] = 7'b0110011;
				ins[31:25] = (r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
			end
			default: begin
				ins[6:0] = 7'b0010011;
				if (f3 == 3'd1) ins[31:25] = 7'h00;
				if (f3 == 3'd5) ins[31:25] = {1'b0, r[30], 5'd0};
			end
		endcase
	endtask

	initial begin
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] ops [0:5];
		integer      i;
		integer      k;
		instr = nop;
		pc_id = 32'd0;
		rs1_data = 32'd0;
		rs2_data = 32'd0;
		{rd_addr_mem, wb_en_mem, mem_fwd_data} = '0;
		{rd_addr_wb, wb_en_wb, wb_data} = '0;
		rst = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#1;
		if (wb_en !== 1'b0) report("wb_en", wb_en, 0);
		if (dm_web !== 1'b1) report("dm_web", dm_web, 1);
		if (pc_sel !== rv_ex_pkg::pc_next) report("pc_sel", pc_sel, rv_ex_pkg::pc_next);
		if (instr_sel !== rv_ex_pkg::ins_normal) report("instr_sel", instr_sel, 0);
		if ({load_kind, store_kind, branch_kind} !== 8'd0)
			report("kind codes", {load_kind, store_kind, branch_kind}, 0);
		end_test("reset");

		for (i = 0; i < 40; i++) begin
			random_alu(ins);
			issue(ins, $random(seed), $random(seed));
			issue(nop, 0, 0);
			issue(nop, 0, 0);
		end
		end_test("independent alu");

		ops = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h0000_0003, 32'h1234_5678,
			32'hfedc_ba98};
		for (i = 0; i < 24; i++) begin
			a = (i < 12) ? ops[i % 6] : $random(seed);
			b = (i < 12) ? ops[(i + 2) % 6] : $random(seed);
			for (k = 0; k < 4; k++) begin
				issue({7'h01, 5'd2, 5'd1, 3'(k), 5'd3, 7'b0110011}, a, b);
				issue(nop, 0, 0);
			end
		end
		end_test("multiplier");

		issue(32'h0020_81b3, 32'd100, 32'd23);          // add x3,x1,x2
		issue(32'h4021_8233, 32'hdead_0000, 32'd3);     // sub x4,x3,x2 uses ex
		set_stages(5'd7, 1'b1, 32'h0000_0500, 5'd7, 1'b1, 32'h0000_0900);
		issue(32'h0003_8413, 32'h1111_1111, 0);         // addi x8,x7,0 takes mem
		set_stages(5'd0, 1'b0, 0, 5'd7, 1'b1, 32'h0000_0900);
		issue(32'h0003_8493, 32'h1111_1111, 0);         // wb only
		set_stages(5'd9, 1'b1, 32'h0bad_0bad, 0, 0, 0);
		issue(32'h0010_0493, 0, 0);                     // addi x9,x0,1
		issue(32'h0004_8513, 32'h2222_2222, 0);         // ex beats mem
		set_stages(5'd0, 1'b1, 32'h0bad_0001, 5'd0, 1'b1, 32'h0bad_0002);
		issue(32'h0000_0593, 32'h0000_0042, 0);         // addi x11,x0,0 sees rs1_data
		end_test("forwarding");

		ops = '{32'd5, 32'd5, 32'hffff_fffb, 32'd3, 32'd3, 32'hffff_fffb};
		for (k = 0; k < 8; k++) begin
			if (k == 2 || k == 3) continue;
			for (i = 0; i < 3; i++) begin
				issue({1'b0, 6'($random(seed)), 5'd2, 5'd1, 3'(k), 5'($random(seed)) & 5'h1e,
					7'b1100011}, ops[2 * i], ops[2 * i + 1]);
				issue(32'h0010_0613, 0, 0); // killed when taken
				issue(nop, 0, 0);
			end
		end
		issue({12'h7f0, 8'h00, 5'd1, 7'b1101111}, 0, 0);          // jal x1
		issue(32'h0010_0693, 0, 0);
		issue(nop, 0, 0);
		issue({12'h010, 5'd5, 3'd0, 5'd1, 7'b1100111}, 32'h0000_2000, 0); // jalr x1,16(x5)
		issue(32'h0010_0693, 0, 0);
		end_test("control flow");

		for (k = 0; k < 8; k++) begin
			if (k == 3 || k > 5) continue;
			issue({12'h024, 5'd1, 3'(k), 5'd12, 7'b0000011}, $random(seed), 0);
			issue(nop, 0, 0);
		end
		for (k = 0; k < 3; k++) begin
			issue({7'h01, 5'd2, 5'd1, 3'(k), 5'd4, 7'b0100011}, $random(seed), $random(seed));
			issue(nop, 0, 0);
		end
		issue(32'h0080_a283, 32'h0000_3000, 0);         // lw x5,8(x1)
		issue(32'h0072_8333, 32'h5555_5555, 32'd7);     // add x6,x5,x7
		#1;
		if (pc_sel !== rv_ex_pkg::pc_hold) report("pc_sel", pc_sel, rv_ex_pkg::pc_hold);
		set_stages(5'd5, 1'b1, 32'h0000_0abc, 0, 0, 0);
		issue(32'h0072_8333, 32'h5555_5555, 32'd7);     // re-presented
		#1;
		if (instr_sel !== rv_ex_pkg::ins_hold)
			report("instr_sel", instr_sel, rv_ex_pkg::ins_hold);
		end_test("loads and stores");

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0 && checks > 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- flist.f
hw/rv_ex_pkg.sv
hw/ex_control.sv
hw/imm_gen.sv
hw/ex_datapath.sv
hw/ex_alu.sv
hw/ex_mul.sv
hw/branch_cmp.sv
hw/ex_stage_top.sv
sim/ex_stage_properties.sv
sim/tb_ex_stage.sv

//--- Bender.yml
package:
  name: rv_ex_stage

sources:
  - files:
      - hw/rv_ex_pkg.sv
      - hw/ex_control.sv
      - hw/imm_gen.sv
      - hw/ex_datapath.sv
      - hw/ex_alu.sv
      - hw/ex_mul.sv
      - hw/branch_cmp.sv
      - hw/ex_stage_top.sv
  - target: simulation
    files:
      - sim/ex_stage_properties.sv
      - sim/tb_ex_stage.sv
